// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fm_buffer_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Done: errors found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fm_buffer_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_buffer_checker (
	input logic clk,
	input logic rst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i
);

	logic [3:0] wait_cnt; // Cycles of strobe without ack

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_cnt <= '0;
		end else if (!(wb_cyc_i && wb_stb_i) || wb_ack_i) begin
			wait_cnt <= '0;
		end else if (wait_cnt != 4'hf) begin
			wait_cnt <= wait_cnt + 4'd1; // Saturates
		end
	end

	ack_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
		else $error("ack without cyc and stb");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("ack high two cycles in a row");

	// Slowest access is an accumulate at 5 edges
	ack_in_time: assert property (@(posedge clk) disable iff (!rst_n_i)
		wait_cnt <= 4'd8)
		else $error("no ack within 8 cycles of strobe");

	ack_low_in_reset: assert property (@(posedge clk)
		!rst_n_i |-> !wb_ack_i)
		else $error("ack high during reset");

endmodule

bind fm_buffer_top fm_buffer_checker fm_buffer_checker_inst (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_i (wb_ack_o)
);

`default_nettype wire

// ==== dv/fm_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fm_defs.svh"

module fm_buffer_tb;
	import fm_pkg::*;

	localparam int ACK_TIMEOUT = 16;

	logic                 clk;
	logic                 rst_n;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [`FM_WB_AW-1:0] wb_adr;
	fm_row_t              wb_dat_w;
	fm_row_t              wb_dat_r;
	logic                 wb_ack;

	fp16_t ref_mem [`FM_WORDS]; // Expected store contents
	int    ref_val [`FM_WORDS]; // Integer behind each word
	int    errors;
	int    checks;
	int    tests;

	tb_clkgen clkgen_inst (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	fm_buffer_top fm_buffer_top_inst (
		.clk      (clk),
		.rst_n_i  (rst_n),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w),
		.wb_dat_o (wb_dat_r),
		.wb_ack_o (wb_ack)
	);

	// Exact half-precision code of an integer below 2048 in magnitude
	function automatic fp16_t int_to_half(int v);
		int    mag;
		int    msb;
		fp16_t h;
		mag = (v < 0) ? -v : v;
		msb = 0;
		if (mag == 0)
			return 16'h0000;
		for (int i = 0; i < 11; i++) begin
			if (mag[i])
				msb = i;
		end
		h[15]    = (v < 0);
		h[14:10] = 5'(msb + 15);
		h[9:0]   = 10'(mag << (10 - msb)); // Hidden bit drops out
		return h;
	endfunction

	function automatic int rand_signed(int span);
		return int'($urandom % (2 * span + 1)) - span;
	endfunction

	// Strobe stays up through the edge that samples ack
	task automatic wait_ack();
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < ACK_TIMEOUT) begin
			@(negedge clk);
			seen = wb_ack;
			n++;
		end
		assert (seen) else begin
			$display("Bus access to address %h got no ack within %0d cycles", wb_adr,
				ACK_TIMEOUT);
			errors++;
		end
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [`FM_WB_AW-1:0] adr, input fm_row_t data);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		wait_ack();
	endtask

	task automatic wb_read(input fm_word_addr_t word, output fm_row_t data);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b0;
		wb_adr   = {1'($urandom), word}; // Bit 4 should not matter
		wb_dat_w = fm_row_t'($urandom);
		wait_ack();
		data = wb_dat_r;
	endtask

	task automatic write_row(input int row, input fp16_t lo, input fp16_t hi);
		wb_write({2'b00, fm_row_addr_t'(row)}, {hi, lo});
		ref_mem[row * `FM_LANES]     = lo;
		ref_mem[row * `FM_LANES + 1] = hi;
	endtask

	task automatic write_int_row(input int row, input int v0, input int v1);
		ref_val[row * `FM_LANES]     = v0;
		ref_val[row * `FM_LANES + 1] = v1;
		write_row(row, int_to_half(v0), int_to_half(v1));
	endtask

	task automatic acc_row(input int row, input int v0, input int v1);
		int w;
		w = row * `FM_LANES;
		wb_write({2'b10, fm_row_addr_t'(row)}, {int_to_half(v1), int_to_half(v0)});
		ref_val[w]     += v0;
		ref_val[w + 1] += v1;
		ref_mem[w]     = int_to_half(ref_val[w]);
		ref_mem[w + 1] = int_to_half(ref_val[w + 1]);
	endtask

	// Word i in the low half, word i+1 mod 16 in the high half
	task automatic check_pair(input int word);
		fm_row_t got;
		fm_row_t exp;
		wb_read(fm_word_addr_t'(word), got);
		exp = {ref_mem[(word + 1) % `FM_WORDS], ref_mem[word]};
		checks++;
		assert (got == exp) else begin
			$display("FAILED at %0d ns: wb_dat_o for word %0d expected %h got %h",
				$time, word, exp, got);
			errors++;
		end
	endtask

	task automatic check_all();
		for (int w = 0; w < `FM_WORDS; w++)
			check_pair(w);
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("%s: pass", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		assert (rst_n === 1'b1) else begin
			$display("Reset was never released");
			errors++;
		end
	endtask

	task automatic check_reset_state();
		int e0;
		e0 = errors;
		check_all();
		end_test("reset state", e0);
	endtask

	task automatic write_then_read();
		int e0;
		e0 = errors;
		for (int r = 0; r < 8; r++)
			write_row(r, fp16_t'($urandom), fp16_t'($urandom));
		check_all();
		end_test("plain write and read", e0);
	endtask

	task automatic wrap_read();
		int e0;
		e0 = errors;
		write_row(7, fp16_t'($urandom), fp16_t'($urandom));
		write_row(0, fp16_t'($urandom), fp16_t'($urandom));
		check_pair(15);
		check_pair(14);
		end_test("wrap-around read", e0);
	endtask

	task automatic accumulate_rows();
		int e0;
		e0 = errors;
		for (int r = 0; r < 8; r++)
			write_int_row(r, rand_signed(200), rand_signed(200));
		for (int k = 0; k < 4; k++) begin
			for (int r = 0; r < 8; r++)
				acc_row(r, rand_signed(100), rand_signed(100));
			check_all(); // Running sums after each pass
		end
		end_test("accumulate", e0);
	endtask

	task automatic cancel_and_sign();
		int e0;
		e0 = errors;
		for (int r = 0; r < 8; r++)
			acc_row(r, -ref_val[r * 2], -ref_val[r * 2 + 1]);
		check_all(); // All words must be +0
		for (int r = 0; r < 8; r++)
			acc_row(r, -1 - int'($urandom % 100), -1 - int'($urandom % 100));
		check_all();
		end_test("cancellation and sign", e0);
	endtask

	task automatic interleave_ops();
		int e0;
		e0 = errors;
		for (int r = 2; r < 8; r += 3) begin
			write_int_row(r, rand_signed(200), rand_signed(200));
			acc_row(r, rand_signed(100), rand_signed(100));
			check_pair(r * 2);
			write_int_row(r, rand_signed(200), rand_signed(200)); // Earlier sum discarded
			check_pair(r * 2);
			acc_row(r, rand_signed(100), rand_signed(100));
			acc_row(r, rand_signed(100), rand_signed(100));
			check_pair(r * 2);
		end
		end_test("interleaving", e0);
	endtask

	initial begin
		void'($urandom(87));
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		for (int w = 0; w < `FM_WORDS; w++) begin
			ref_mem[w] = '0;
			ref_val[w] = 0;
		end
		wait_reset_release();
		check_reset_state();
		write_then_read();
		wrap_read();
		accumulate_rows();
		cancel_and_sign();
		interleave_ops();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset from time zero, released on a falling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hw/fm_pkg.sv
hw/fm_port_if.sv
hw/fp16_add.sv
hw/fm_ram_acc.sv
hw/wb_fm_slave.sv
hw/fm_buffer_top.sv
dv/tb_clkgen.sv
dv/fm_buffer_checker.sv
dv/fm_buffer_tb.sv

// ==== hw/fm_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fm_defs.svh"

module fm_buffer_top (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [`FM_WB_AW-1:0] wb_adr_i,
	input  fm_pkg::fm_row_t      wb_dat_i,
	output fm_pkg::fm_row_t      wb_dat_o,
	output logic                 wb_ack_o
);

	// Buffer access port between bus slave and store
	fm_port_if port_if ();

	wb_fm_slave wb_fm_slave_inst (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.port     (port_if.master)
	);

	// Store with the two lane adders
	fm_ram_acc fm_ram_acc_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.port    (port_if.store)
	);

endmodule

`default_nettype wire

// ==== hw/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

	`include "fm_defs.svh"

	// Half-precision word, sign/exponent/fraction = 1/5/10
	typedef logic [`FM_LANE_W-1:0] fp16_t;

	// Lane 0 in the low half, at the lower word address
	typedef logic [`FM_LANES*`FM_LANE_W-1:0] fm_row_t;

	typedef logic [`FM_ROW_AW-1:0]  fm_row_addr_t;
	typedef logic [`FM_WORD_AW-1:0] fm_word_addr_t;

	// Bus slave sequencing
	typedef enum logic [1:0] {
		WB_IDLE,
		WB_BUSY, // Command issued, waiting for done
		WB_ACK
	} wb_state_e;

endpackage

`default_nettype wire

// ==== hw/fm_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fm_defs.svh"

interface fm_port_if;
	import fm_pkg::*;

	logic          wr_en;   // Write command, one cycle
	logic          acc_en;  // Qualifies wr_en: add into the row
	fm_row_addr_t  wr_row;
	fm_row_t       wr_data;
	logic          rd_en;   // Paired read command, one cycle
	fm_word_addr_t rd_word; // First word of the pair
	fm_row_t       rd_data;
	logic          done;    // Completion of any command

	// Bus side issues commands
	modport master (
		output wr_en, acc_en, wr_row, wr_data, rd_en, rd_word,
		input  rd_data, done
	);

	// Buffer side executes them
	modport store (
		input  wr_en, acc_en, wr_row, wr_data, rd_en, rd_word,
		output rd_data, done
	);

endinterface

`default_nettype wire

// ==== hw/fm_ram_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fm_defs.svh"

module fm_ram_acc (
	input logic      clk,
	input logic      rst_n_i,
	fm_port_if.store port
);
	import fm_pkg::*;

	fp16_t                mem [`FM_WORDS];
	logic [1:0]           acc_phase;  // 0 idle, 1 operands latched, 2 sum pending
	fm_row_addr_t         acc_row;
	fm_row_t              add_a;      // Stored row
	fm_row_t              add_b;      // Incoming row
	logic                 add_valid;
	logic [`FM_LANES-1:0] sum_valid;
	fp16_t                sum_lane [`FM_LANES];
	logic                 write_back;
	fm_word_addr_t        rd_next;

	function automatic fm_word_addr_t word_of(fm_row_addr_t row, int lane);
		return fm_word_addr_t'(int'(row) * `FM_LANES + lane);
	endfunction

	assign add_valid  = (acc_phase == 2'd1);
	assign write_back = (acc_phase == 2'd2) && (&sum_valid);
	assign rd_next    = port.rd_word + fm_word_addr_t'(1); // Wraps past the last word

	for (genvar g = 0; g < `FM_LANES; g++) begin : g_lane
		fp16_add add_inst (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.in_valid_i  (add_valid),
			.a_i         (add_a[g*`FM_LANE_W +: `FM_LANE_W]),
			.b_i         (add_b[g*`FM_LANE_W +: `FM_LANE_W]),
			.out_valid_o (sum_valid[g]),
			.sum_o       (sum_lane[g])
		);
	end

	// Store, all words +0.0 after reset
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int w = 0; w < `FM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else if (write_back) begin
			for (int l = 0; l < `FM_LANES; l++) begin
				mem[word_of(acc_row, l)] <= sum_lane[l];
			end
		end else if (port.wr_en && !port.acc_en) begin
			for (int l = 0; l < `FM_LANES; l++) begin
				mem[word_of(port.wr_row, l)] <= port.wr_data[l*`FM_LANE_W +: `FM_LANE_W];
			end
		end
	end

	// Accumulate sequencing and completion
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_phase <= 2'd0;
			port.done <= 1'b0;
		end else begin
			port.done <= (port.wr_en && !port.acc_en) || port.rd_en || write_back;
			case (acc_phase)
				2'd0: begin
					if (port.wr_en && port.acc_en)
						acc_phase <= 2'd1;
				end
				2'd1: acc_phase <= 2'd2; // Adders register this edge
				default: begin
					if (write_back)
						acc_phase <= 2'd0;
				end
			endcase
		end
	end

	// Operand capture and paired read
	always_ff @(posedge clk) begin
		if (port.wr_en && port.acc_en) begin
			acc_row <= port.wr_row;
			add_b   <= port.wr_data;
			for (int l = 0; l < `FM_LANES; l++) begin
				add_a[l*`FM_LANE_W +: `FM_LANE_W] <= mem[word_of(port.wr_row, l)];
			end
		end
		if (port.rd_en) begin
			port.rd_data <= {mem[rd_next], mem[port.rd_word]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/fp16_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp16_add (
	input  logic          clk,
	input  logic          rst_n_i,
	input  logic          in_valid_i,
	input  fm_pkg::fp16_t a_i,
	input  fm_pkg::fp16_t b_i,
	output logic          out_valid_o,
	output fm_pkg::fp16_t sum_o
);
	import fm_pkg::*;

	// Hidden bit, 10 fraction bits and 3 guard bits
	localparam int MW = 14;

	logic              a_big;
	logic              big_sign;
	logic [4:0]        big_exp;
	logic [4:0]        small_exp;
	logic [4:0]        exp_diff;
	logic [MW-1:0]     big_man;
	logic [MW-1:0]     small_man;
	logic [MW-1:0]     small_shift;
	logic [MW-1:0]     lost_mask;
	logic              sticky;
	logic [MW-1:0]     small_al;
	logic              eff_sub;
	logic [MW:0]       raw_sum;
	logic [3:0]        lead_zeros;
	logic              lead_found;
	logic [MW:0]       norm_sum;
	logic signed [6:0] exp_res;
	fp16_t             sum_c;

	// Zero exponent reads as zero, subnormal inputs included
	function automatic logic [MW-1:0] unpack(fp16_t x);
		if (x[14:10] != 5'd0)
			return {1'b1, x[9:0], 3'b000};
		return '0;
	endfunction

	// Order by magnitude so the difference never goes negative
	assign a_big     = a_i[14:0] >= b_i[14:0];
	assign big_sign  = a_big ? a_i[15] : b_i[15];
	assign big_exp   = a_big ? a_i[14:10] : b_i[14:10];
	assign small_exp = a_big ? b_i[14:10] : a_i[14:10];
	assign big_man   = unpack(a_big ? a_i : b_i);
	assign small_man = unpack(a_big ? b_i : a_i);

	// Alignment
	assign exp_diff    = big_exp - small_exp;
	assign small_shift = small_man >> exp_diff;
	assign lost_mask   = (MW'(1) << exp_diff) - MW'(1);
	assign sticky      = |(small_man & lost_mask); // Keeps truncation correct on subtract
	assign small_al    = small_shift | {{(MW-1){1'b0}}, sticky};

	assign eff_sub = a_i[15] ^ b_i[15];
	assign raw_sum = eff_sub ? {1'b0, big_man} - {1'b0, small_al}
	                         : {1'b0, big_man} + {1'b0, small_al};

	// Leading-zero search over the raw sum
	always_comb begin
		lead_zeros = 4'd0;
		lead_found = 1'b0;
		for (int i = MW; i >= 0; i--) begin
			if (!lead_found && raw_sum[i]) begin
				lead_zeros = 4'(MW - i);
				lead_found = 1'b1;
			end
		end
	end

	assign norm_sum = raw_sum << lead_zeros; // Leading one ends up in the top bit
	assign exp_res  = $signed({2'b00, big_exp}) + 7'sd1 - $signed({3'b000, lead_zeros});

	// Pack with truncation, flush and saturation to infinity
	always_comb begin
		if (!lead_found || exp_res <= 7'sd0) begin
			sum_c = '0; // Cancellation or underflow gives +0
		end else if (exp_res >= 7'sd31) begin
			sum_c = {big_sign, 5'h1f, 10'h000};
		end else begin
			sum_c = {big_sign, exp_res[4:0], norm_sum[MW-1 -: 10]};
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o <= 1'b0;
		end else begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i) begin
			sum_o <= sum_c;
		end
	end

endmodule

`default_nettype wire

// ==== hw/wb_fm_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fm_defs.svh"

module wb_fm_slave (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [`FM_WB_AW-1:0] wb_adr_i,
	input  logic [`FM_WB_DW-1:0] wb_dat_i,
	output logic [`FM_WB_DW-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	fm_port_if.master            port
);
	import fm_pkg::*;

	wb_state_e state;
	logic      req;       // Strobe sampled while idle
	logic      is_read;
	logic      finish;

	assign req    = wb_cyc_i && wb_stb_i && (state == WB_IDLE);
	assign finish = (state == WB_BUSY) && port.done;

	// FSM, command pulses and ack
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state       <= WB_IDLE;
			wb_ack_o    <= 1'b0;
			port.wr_en  <= 1'b0;
			port.acc_en <= 1'b0;
			port.rd_en  <= 1'b0;
		end else begin
			port.wr_en  <= req && wb_we_i;
			port.acc_en <= req && wb_we_i && wb_adr_i[`FM_WB_AW-1];
			port.rd_en  <= req && !wb_we_i;
			wb_ack_o    <= finish; // One edge after done

			case (state)
				WB_IDLE: begin
					if (req)
						state <= WB_BUSY;
				end
				WB_BUSY: begin
					if (port.done)
						state <= WB_ACK;
				end
				default: state <= WB_IDLE; // Ack cycle, strobe not resampled
			endcase
		end
	end

	// Address decode and data capture
	always_ff @(posedge clk) begin
		if (req) begin
			port.wr_row  <= wb_adr_i[`FM_ROW_AW-1:0];
			port.wr_data <= wb_dat_i;
			port.rd_word <= wb_adr_i[`FM_WORD_AW-1:0]; // Bit 4 ignored on reads
			is_read      <= !wb_we_i;
		end
		if (finish && is_read) begin
			wb_dat_o <= port.rd_data;
		end
	end

endmodule

`default_nettype wire

// ==== include/fm_defs.svh ====
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

// Row geometry

// One half word
`define FM_LANE_W  16
// Half words per row
`define FM_LANES   2
// Half words in the store
`define FM_WORDS   16

// Address widths

// 8 rows of 2 words
`define FM_ROW_AW  3
`define FM_WORD_AW 4

// Wishbone side, bit 4 of the address selects accumulate on writes
`define FM_WB_AW   5
// One full row per bus beat
`define FM_WB_DW   32

`endif
